// ==== src/mvuPkg.sv ====
`default_nettype none

package mvuPkg;

	// Matrix geometry
	localparam int unsigned Pe = 4;      // Rows per cycle
	localparam int unsigned Simd = 4;    // Columns per cycle
	localparam int unsigned MatH = 8;
	localparam int unsigned MatW = 16;
	localparam int unsigned NeuronFolds = MatH / Pe;  // Row groups
	localparam int unsigned SynFolds = MatW / Simd;   // Column folds per row group

	// Address widths
	localparam int unsigned FoldAddrWidth = 2;
	localparam int unsigned NeuronAddrWidth = 1;
	localparam int unsigned WeightAddrWidth = 7;     // Row in the upper 3 bits and column in the lower 4

	// Accumulator and lane packing
	localparam int unsigned AccuWidth = 16;
	localparam int unsigned LaneOffsets[Pe] = '{0, 8, 15, 22};
	localparam int unsigned ProdWidth = LaneOffsets[Pe-1] + AccuWidth;  // Packed product word
	localparam int unsigned HiWidth = AccuWidth - 7;   // Lane-crossing correction accumulator
	localparam int unsigned HiSumWidth = 4;            // Sum of Simd values in [-1:1]
	localparam int unsigned LoSumWidth = 10;           // Sum of Simd 8-bit low fields

	// Sequencer states
	typedef enum logic [1:0] {
		Idle,
		Feed,
		Flush,
		Done
	} seqState_e;

endpackage

`default_nettype wire

// ==== src/coreFeedIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Per-cycle beat from the sequencer into the compute core
interface coreFeedIf import mvuPkg::*; ();

	logic en;    // Advances every core stage
	logic last;  // Final fold of a row group
	logic zero;  // Forces this partial product to zero
	logic signed [Pe-1:0][Simd-1:0][3:0] w;  // Signed weights
	logic [Simd-1:0][3:0] a;                 // Unsigned activations

	modport seq (
		output en,
		output last,
		output zero,
		output w,
		output a
	);

	modport core (
		input en,
		input last,
		input zero,
		input w,
		input a
	);

endinterface

`default_nettype wire

// ==== src/weightMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightMem import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [WeightAddrWidth-1:0] addr,
	input logic [3:0] data,
	input logic [NeuronAddrWidth-1:0] nf,  // Row group being read
	input logic [FoldAddrWidth-1:0] sf,    // Column fold being read
	output logic signed [Pe-1:0][Simd-1:0][3:0] row
);

	logic [3:0] mem [MatH][MatW];
	logic [2:0] wrRow;
	logic [3:0] wrCol;

	assign wrRow = addr[6:4];  // Row-major weight addressing
	assign wrCol = addr[3:0];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wrRow][wrCol] <= data;
		end
	end

	// Block of Pe rows by Simd columns for the current walk position
	always_comb begin
		for (int pe = 0; pe < Pe; pe++) begin
			for (int s = 0; s < Simd; s++) begin
				row[pe][s] = mem[nf * Pe + pe][sf * Simd + s];
			end
		end
	end

	// The walk counters sit at zero outside a run,
	// so a write that sees them moving lands in the middle of a run
	assert property (@(posedge clk) disable iff (rst)
		we |-> (nf == '0) && (sf == '0) && $stable(sf))
		else $error("weight write during an active run");

endmodule

`default_nettype wire

// ==== src/actBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module actBuffer import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [FoldAddrWidth-1:0] fold,
	input logic [Simd-1:0][3:0] data,
	input logic clear,  // All folds go stale at the end of a run
	input logic [FoldAddrWidth-1:0] rdFold,
	output logic [Simd-1:0][3:0] rdData,
	output logic rdValid
);

	logic [Simd-1:0][3:0] mem [SynFolds];
	logic [SynFolds-1:0] written;  // One fresh flag per fold

	always_ff @(posedge clk) begin
		if (we) begin
			mem[fold] <= data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			written <= '0;
		end else if (clear) begin
			written <= '0;  // Writes are not allowed while the run is up
		end else if (we) begin
			written[fold] <= 1'b1;
		end
	end

	assign rdData = mem[rdFold];
	assign rdValid = written[rdFold];

endmodule

`default_nettype wire

// ==== src/mvuSeqCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mvuSeqCtrl import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic runReq,
	input logic stall,        // Result queue full
	input logic empty,        // Result queue drained
	input logic pendingLast,  // A last beat is still inside the core
	input logic rdValid,      // Current activation fold is fresh
	input logic signed [Pe-1:0][Simd-1:0][3:0] row,
	input logic [Simd-1:0][3:0] rdData,
	output logic runAck,
	output logic [NeuronAddrWidth-1:0] nf,
	output logic [FoldAddrWidth-1:0] sf,
	output logic clear,
	coreFeedIf.seq feed
);

	seqState_e state;
	logic lastFold;
	logic lastGroup;
	logic active;

	assign lastFold = (sf == FoldAddrWidth'(SynFolds - 1));
	assign lastGroup = (nf == NeuronAddrWidth'(NeuronFolds - 1));
	assign active = (state == Feed);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			nf <= '0;
			sf <= '0;
			runAck <= 1'b0;
		end else begin
			case (state)
				Idle: begin
					if (runReq) begin
						state <= Feed;
					end
				end
				Feed: begin
					if (!stall) begin  // Beat taken so the walk advances
						sf <= sf + 1'b1;
						if (lastFold) begin
							nf <= nf + 1'b1;
							if (lastGroup) begin
								state <= Flush;  // Counters wrap back to zero here
							end
						end
					end
				end
				Flush: begin
					if (empty && !pendingLast) begin
						state <= Done;
						runAck <= 1'b1;
					end
				end
				Done: begin
					if (!runReq) begin
						state <= Idle;
						runAck <= 1'b0;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	assign clear = (state == Done) && !runReq;  // Fold flags go stale with the ack drop

	// Core beat is zero outside Feed so idle cycles add nothing
	assign feed.en = !stall;
	assign feed.last = active && lastFold;
	assign feed.zero = !(active && rdValid);  // Unwritten fold counts as zero
	assign feed.w = active ? row : '0;
	assign feed.a = (active && rdValid) ? rdData : '0;

	// Core and queue stay drained for as long as the run is acknowledged
	assert property (@(posedge clk) disable iff (rst)
		runAck |-> !pendingLast && empty)
		else $error("runAck raised with a beat pending");

endmodule

`default_nettype wire

// ==== src/packedDotCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module packedDotCore import mvuPkg::*; (
	input logic clk,
	input logic rst,
	coreFeedIf.core feed,
	output logic vld,
	output logic signed [Pe-1:0][AccuWidth-1:0] p,
	output logic pendingLast
);

	logic [1:5] lastPipe;  // Last flag per stage
	logic [ProdWidth-1:0] p3 [Simd];
	logic signed [1:0] h3 [Simd][3];  // Lane-crossing overflow per column
	logic signed [HiSumWidth-1:0] hiSum [3];
	logic [LoSumWidth-1:0] loSum [3];
	logic [AccuWidth-1:0] upSum;
	logic signed [HiWidth-1:0] hi4 [3];
	logic [LoSumWidth-1:0] lo4 [3];
	logic [AccuWidth-1:0] up4;
	logic [Pe-1:0][AccuWidth-1:0] res5;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastPipe <= '0;
		end else if (feed.en) begin
			lastPipe <= {feed.last, lastPipe[1:4]};
		end
	end
	assign vld = lastPipe[5];
	assign pendingLast = |lastPipe;

	for (genvar s = 0; s < Simd; s++) begin : genSimd
		logic [ProdWidth-1:0] dd;  // Packed low weight bits
		logic [ProdWidth-1:0] aa;  // Weight sign bits to subtract
		logic [1:0] xx [1:3];      // Canary products
		logic signed [4:0] b1;
		logic signed [ProdWidth-1:0] ad1;
		logic signed [ProdWidth-1:0] m2;
		logic [ProdWidth-1:0] acc3;
		logic [1:0] x1 [1:3];
		logic [1:0] x2 [1:3];
		logic [1:0] x3 [1:3];

		// Lane assembly of the Pe weights with sign correction
		always_comb begin
			dd = '0;
			aa = '0;
			for (int pe = 0; pe < Pe; pe++) begin
				dd[LaneOffsets[pe] +: 3] = feed.w[pe][s][2:0];
				aa[LaneOffsets[pe] + 3] = feed.w[pe][s][3];
			end
			for (int pe = 1; pe < Pe; pe++) begin
				xx[pe] = feed.zero ? 2'b00 : 2'(feed.w[pe][s][1:0] * feed.a[s][1:0]);
			end
		end

		always_ff @(posedge clk) begin
			if (rst) begin
				b1 <= '0;
				ad1 <= '0;
				m2 <= '0;
				acc3 <= '0;
				x1 <= '{default: '0};
				x2 <= '{default: '0};
				x3 <= '{default: '0};
			end else if (feed.en) begin
				b1 <= feed.zero ? 5'sd0 : $signed({1'b0, feed.a[s]});  // Stage 1
				ad1 <= $signed(dd - aa);  // Signed lane-packed weight word
				m2 <= b1 * ad1;           // Stage 2 wide multiply
				acc3 <= m2 + (lastPipe[3] ? '0 : acc3);  // Stage 3 restarts after a last beat
				x1 <= xx;
				x2 <= x1;
				for (int i = 1; i < Pe; i++) begin
					x3[i] <= x2[i] + (lastPipe[3] ? 2'b00 : acc3[LaneOffsets[i] +: 2]);
				end
			end
		end

		assign p3[s] = acc3;
		for (genvar i = 0; i < 3; i++) begin : genCross
			assign h3[s][i] = acc3[LaneOffsets[i+1] +: 2] - x3[i+1];  // Carry into lane i+1
		end
	end

	// Stage 4 sums across columns
	always_comb begin
		upSum = '0;
		for (int i = 0; i < 3; i++) begin
			hiSum[i] = '0;
			loSum[i] = '0;
			for (int s = 0; s < Simd; s++) begin
				hiSum[i] += h3[s][i];
				loSum[i] += LoSumWidth'((p3[s] >> LaneOffsets[i]) &
					((ProdWidth'(1) << (LaneOffsets[i+1] - LaneOffsets[i])) - 1'b1));
			end
		end
		for (int s = 0; s < Simd; s++) begin
			upSum += AccuWidth'(p3[s] >> LaneOffsets[Pe-1]);  // Top lane takes all upper bits
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hi4 <= '{default: '0};
			lo4 <= '{default: '0};
			up4 <= '0;
			res5 <= '0;
		end else if (feed.en) begin
			for (int i = 0; i < 3; i++) begin
				hi4[i] <= (lastPipe[4] ? 9'sd0 : hi4[i]) + hiSum[i];  // High sideband
				lo4[i] <= loSum[i];
			end
			up4 <= upSum;
			// Stage 5 resolves each lane from its low field and neighbor carries
			res5[3] <= up4 - AccuWidth'(hi4[2]);
			res5[2] <= (AccuWidth'(hi4[2]) << (LaneOffsets[3] - LaneOffsets[2]))
				+ AccuWidth'(lo4[2]) - AccuWidth'(hi4[1]);
			res5[1] <= (AccuWidth'(hi4[1]) << (LaneOffsets[2] - LaneOffsets[1]))
				+ AccuWidth'(lo4[1]) - AccuWidth'(hi4[0]);
			res5[0] <= (AccuWidth'(hi4[0]) << (LaneOffsets[1] - LaneOffsets[0]))
				+ AccuWidth'(lo4[0]);
		end
	end

	assign p = res5;

	// A closing beat must carry defined data or the whole row group is lost
	assert property (@(posedge clk) disable iff (rst)
		feed.en && feed.last |-> !$isunknown(feed.w) && !$isunknown(feed.a))
		else $error("last beat with unknown data");

endmodule

`default_nettype wire

// ==== src/resultDrain.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultDrain import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic vld,
	input logic en,
	input logic signed [Pe-1:0][AccuWidth-1:0] p,
	input logic resAck,
	output logic resReq,
	output logic signed [Pe-1:0][AccuWidth-1:0] resData,
	output logic stall,
	output logic empty
);

	logic signed [Pe-1:0][AccuWidth-1:0] q [2];
	logic wrPtr;
	logic rdPtr;
	logic [1:0] count;
	logic waitDrop;  // Ack seen and the host still has to release it
	logic push;
	logic pop;

	assign push = vld && en;
	assign pop = resReq && resAck;

	always_ff @(posedge clk) begin
		if (push) begin
			q[wrPtr] <= p;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
			count <= '0;
			resReq <= 1'b0;
			waitDrop <= 1'b0;
		end else begin
			if (push) wrPtr <= !wrPtr;
			if (pop) rdPtr <= !rdPtr;
			count <= count + push - pop;
			if (pop) begin
				resReq <= 1'b0;
				waitDrop <= 1'b1;
			end else if (waitDrop) begin
				waitDrop <= resAck;  // Next request only after ack drops
			end else if (!resReq && count != '0) begin
				resReq <= 1'b1;  // Data is already stable in the head entry
			end
		end
	end

	assign resData = q[rdPtr];
	assign stall = (count == 2'd2);
	assign empty = (count == '0);

	// Back-pressure from this queue must hold the core before it overruns
	assert property (@(posedge clk) disable iff (rst) !(push && count == 2'd2))
		else $error("result captured into a full queue");

endmodule

`default_nettype wire

// ==== src/mvuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mvuTop import mvuPkg::*; (
	input logic clk,
	input logic rst,
	input logic wWe,
	input logic [WeightAddrWidth-1:0] wAddr,
	input logic [3:0] wData,
	input logic aWe,
	input logic [FoldAddrWidth-1:0] aFold,
	input logic [Simd-1:0][3:0] aData,
	input logic runReq,
	output logic runAck,
	output logic resReq,
	input logic resAck,
	output logic signed [Pe-1:0][AccuWidth-1:0] resData
);

	logic [NeuronAddrWidth-1:0] nf;
	logic [FoldAddrWidth-1:0] sf;
	logic signed [Pe-1:0][Simd-1:0][3:0] wRow;
	logic [Simd-1:0][3:0] actData;
	logic actValid;
	logic clear;
	logic stall;
	logic empty;
	logic pendingLast;
	logic vld;
	logic signed [Pe-1:0][AccuWidth-1:0] accu;

	coreFeedIf feedIf ();

	weightMem u_weightMem (
		.clk  (clk),
		.rst  (rst),
		.we   (wWe),
		.addr (wAddr),
		.data (wData),
		.nf   (nf),
		.sf   (sf),
		.row  (wRow)
	);

	actBuffer u_actBuffer (
		.clk     (clk),
		.rst     (rst),
		.we      (aWe),
		.fold    (aFold),
		.data    (aData),
		.clear   (clear),
		.rdFold  (sf),
		.rdData  (actData),
		.rdValid (actValid)
	);

	mvuSeqCtrl u_seqCtrl (
		.clk         (clk),
		.rst         (rst),
		.runReq      (runReq),
		.stall       (stall),
		.empty       (empty),
		.pendingLast (pendingLast),
		.rdValid     (actValid),
		.row         (wRow),
		.rdData      (actData),
		.runAck      (runAck),
		.nf          (nf),
		.sf          (sf),
		.clear       (clear),
		.feed        (feedIf.seq)
	);

	packedDotCore u_core (
		.clk         (clk),
		.rst         (rst),
		.feed        (feedIf.core),
		.vld         (vld),
		.p           (accu),
		.pendingLast (pendingLast)
	);

	resultDrain u_drain (
		.clk     (clk),
		.rst     (rst),
		.vld     (vld),
		.en      (feedIf.en),  // Capture only on cycles the core advances
		.p       (accu),
		.resAck  (resAck),
		.resReq  (resReq),
		.resData (resData),
		.stall   (stall),
		.empty   (empty)
	);

endmodule

`default_nettype wire

// ==== dv/mvuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mvuTb import mvuPkg::*; ();

	localparam int NumRuns = 5;      // Records in the stim file
	localparam int RecWords = 12;    // 8 weight rows, act, mask, 2 expected words
	localparam int ActWord = 8;
	localparam int MaskWord = 9;
	localparam int ExpWord = 10;     // Row group g expected at ExpWord + g
	localparam int WaitLimit = 200;  // Cycles before a handshake counts as hung
	localparam int AckHold = 40;     // Back-pressure on the first result of the last run

	logic clk = 1'b0;
	logic rst;
	logic wWe;
	logic [WeightAddrWidth-1:0] wAddr;
	logic [3:0] wData;
	logic aWe;
	logic [FoldAddrWidth-1:0] aFold;
	logic [Simd-1:0][3:0] aData;
	logic runReq;
	logic runAck;
	logic resReq;
	logic resAck;
	logic signed [Pe-1:0][AccuWidth-1:0] resData;

	logic [63:0] stim [NumRuns * RecWords];

	always #50 clk = ~clk;  // 100 ns period

	mvuTop u_dut (
		.clk     (clk),
		.rst     (rst),
		.wWe     (wWe),
		.wAddr   (wAddr),
		.wData   (wData),
		.aWe     (aWe),
		.aFold   (aFold),
		.aData   (aData),
		.runReq  (runReq),
		.runAck  (runAck),
		.resReq  (resReq),
		.resAck  (resAck),
		.resData (resData)
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("ERROR at %0t ns: %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	// Polls on falling edges until the chosen output reaches the level
	task automatic waitLevel(input bit onRunAck, input logic level, input string what);
		int cycles;
		cycles = 0;
		while (((onRunAck ? runAck : resReq) !== level) && cycles < WaitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if ((onRunAck ? runAck : resReq) !== level) begin
			failRun($sformatf("Handshake hung: no %s within %0d cycles", what, WaitLimit));
		end
	endtask

	task automatic loadWeights(input int base);
		for (int r = 0; r < MatH; r++) begin
			for (int c = 0; c < MatW; c++) begin
				@(negedge clk);
				wWe = 1'b1;
				wAddr = WeightAddrWidth'(r * MatW + c);  // Row in upper bits
				wData = stim[base + r][c * 4 +: 4];
			end
		end
		@(negedge clk);
		wWe = 1'b0;
	endtask

	// Only folds set in the mask are written and the rest stay stale
	task automatic loadActs(input int base);
		for (int f = 0; f < SynFolds; f++) begin
			if (stim[base + MaskWord][f]) begin
				@(negedge clk);
				aWe = 1'b1;
				aFold = FoldAddrWidth'(f);
				aData = stim[base + ActWord][f * Simd * 4 +: Simd * 4];
			end
		end
		@(negedge clk);
		aWe = 1'b0;
	endtask

	task automatic runOnce(input int idx);
		int base;
		base = idx * RecWords;
		loadWeights(base);
		loadActs(base);
		@(negedge clk);
		runReq = 1'b1;
		for (int g = 0; g < NeuronFolds; g++) begin
			waitLevel(1'b0, 1'b1, $sformatf("resReq rise for row group %0d", g));
			checkValue("runAck", 64'd0, runAck);  // Run not over while results remain
			checkValue($sformatf("resData run %0d group %0d", idx, g),
				stim[base + ExpWord + g], resData);
			if (idx == NumRuns - 1 && g == 0) begin
				repeat (AckHold) @(negedge clk);  // Queue fills up behind this entry
				checkValue("resReq", 64'd1, resReq);
				checkValue("resData held", stim[base + ExpWord], resData);
			end
			resAck = 1'b1;
			waitLevel(1'b0, 1'b0, "resReq drop after resAck");
			resAck = 1'b0;
		end
		waitLevel(1'b1, 1'b1, "runAck rise");
		checkValue("resReq", 64'd0, resReq);  // A repeated result would still be pending
		runReq = 1'b0;
		waitLevel(1'b1, 1'b0, "runAck drop after runReq drop");
	endtask

	initial begin
		rst = 1'b1;
		wWe = 1'b0;
		wAddr = '0;
		wData = '0;
		aWe = 1'b0;
		aFold = '0;
		aData = '0;
		runReq = 1'b0;
		resAck = 1'b0;
		$readmemh("dv/mvuStim.txt", stim);
		if ($isunknown(stim[NumRuns * RecWords - 1])) begin
			failRun("Stim file dv/mvuStim.txt is missing or too short");
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkValue("runAck", 64'd0, runAck);  // Idle outputs after reset
		checkValue("resReq", 64'd0, resReq);
		for (int i = 0; i < NumRuns; i++) begin
			runOnce(i);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/mvuStim.txt ====
// Per run: weight rows 0-3, weight rows 4-7 (nibble c = column c, signed)
// then activations (nibble c = column c), fold mask, expected rows 3..0, expected rows 7..4
// Run 0: all folds written, extremes -8 x 15
8888888888888888 7777777777777777 FFFFFFFFFFFFFFFF 7878787878787878
0000000000000000 1111111111111111 7654321076543210 FEDCBA98FEDCBA98
FFFFFFFFFFFFFFFF 000000000000000F FF88FF100690F880 FBC8034800F00000
// Run 1: mixed signs, every lane borrows from or carries into its neighbor
8888888888888888 7777777777777777 8787878787878787 7878787878787878
FFFFFFFFFFFFFFFF 8888888888888888 9999999999999999 7777777777777777
FEDCBA9876543210 000000000000000F 0000FF880348FC40 0348FCB8FC40FF88
// Run 2: only folds 0 and 2 written
0123456789ABCDEF 8888888888888888 7777777777777777 FFFF0000FFFF0000
0000FFFF0000FFFF 1111111111111111 9999999999999999 1234567812345678
FFFFFFFFFFFFFFFF 0000000000000005 00000348FC4000B4 012CFCB80078FF88
// Run 3: no fold written since the last run
0123456789ABCDEF 8888888888888888 7777777777777777 FFFF0000FFFF0000
0000FFFF0000FFFF 1111111111111111 9999999999999999 1234567812345678
FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000 0000000000000000
// Run 4: repeat of run 0, first result held back
8888888888888888 7777777777777777 FFFFFFFFFFFFFFFF 7878787878787878
0000000000000000 1111111111111111 7654321076543210 FEDCBA98FEDCBA98
FFFFFFFFFFFFFFFF 000000000000000F FF88FF100690F880 FBC8034800F00000

// ==== verilog.f ====
src/mvuPkg.sv
src/coreFeedIf.sv
src/weightMem.sv
src/actBuffer.sv
src/mvuSeqCtrl.sv
src/packedDotCore.sv
src/resultDrain.sv
src/mvuTop.sv
dv/mvuTb.sv
